/* hw/gat_dbg_pkg.sv */
package gat_dbg_pkg;

  // one word as seen by the host or logic analyzer
  typedef logic [31:0] dbg_word_t;

  // a single sparse PE lane result
  typedef logic [11:0] pe_data_t;

  // weight BRAM port A address
  typedef logic [13:0] wgt_addr_t;

  // feature BRAM write address
  typedef logic [15:0] feat_addr_t;

  // one sticky bit per stage strobe
  typedef logic [7:0] stage_flags_t;

  // bit positions inside stage_flags_t, spmm valid is the top bit
  localparam int unsigned FLAG_SPMM_VLD = 7;
  localparam int unsigned FLAG_SPMM_RDY = 6;
  localparam int unsigned FLAG_DMVM_VLD = 5;
  localparam int unsigned FLAG_DMVM_RDY = 4;
  localparam int unsigned FLAG_SM_VLD   = 3;
  localparam int unsigned FLAG_SM_RDY   = 2;
  localparam int unsigned FLAG_AGGR_VLD = 1;
  localparam int unsigned FLAG_AGGR_RDY = 0;

endpackage

/* hw/dbg_if.sv */
// sticky stage flags from the input side to the output side
interface stage_flags_if import gat_dbg_pkg::*; ();

  stage_flags_t flags;
  logic         feat_write_seen;

  modport src (
    output flags,
    output feat_write_seen
  );

  modport dst (
    input flags,
    input feat_write_seen
  );

endinterface

// captured lane values, softmax count and feature range state
interface snapshot_if import gat_dbg_pkg::*; ();

  pe_data_t   snap_a;
  pe_data_t   snap_b;
  logic       snap_a_hit;
  logic       snap_b_hit;
  dbg_word_t  sm_vld_count;
  logic       feat_over_seen;
  feat_addr_t feat_last_over;

  modport src (
    output snap_a, snap_b, snap_a_hit, snap_b_hit,
    output sm_vld_count, feat_over_seen, feat_last_over
  );

  modport dst (
    input snap_a, snap_b, snap_a_hit, snap_b_hit,
    input sm_vld_count, feat_over_seen, feat_last_over
  );

endinterface

/* hw/stage_flag_latch.sv */
module stage_flag_latch import gat_dbg_pkg::*; (
  input  logic              clk,
  input  logic              rst_n,
  input  logic              clr_i,
  input  logic              spmm_vld_i,
  input  logic              spmm_rdy_i,
  input  logic              dmvm_vld_i,
  input  logic              dmvm_rdy_i,
  input  logic              sm_vld_i,
  input  logic              sm_rdy_i,
  input  logic              aggr_vld_i,
  input  logic              aggr_rdy_i,
  input  logic              feat_ena_i,
  stage_flags_if.src        status_o
);

  stage_flags_t strobes;
  stage_flags_t flags_q;
  logic         feat_seen_q;

  // gather the raw strobes into flag order
  always_comb begin
    strobes                = '0;
    strobes[FLAG_SPMM_VLD] = spmm_vld_i;
    strobes[FLAG_SPMM_RDY] = spmm_rdy_i;
    strobes[FLAG_DMVM_VLD] = dmvm_vld_i;
    strobes[FLAG_DMVM_RDY] = dmvm_rdy_i;
    strobes[FLAG_SM_VLD]   = sm_vld_i;
    strobes[FLAG_SM_RDY]   = sm_rdy_i;
    strobes[FLAG_AGGR_VLD] = aggr_vld_i;
    strobes[FLAG_AGGR_RDY] = aggr_rdy_i;
  end

  // clear has priority over a strobe on the same edge
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      flags_q     <= '0;
      feat_seen_q <= 1'b0;
    end else if (clr_i) begin
      flags_q     <= '0;
      feat_seen_q <= 1'b0;
    end else begin
      flags_q     <= flags_q | strobes;
      feat_seen_q <= feat_seen_q | feat_ena_i;
    end
  end

  assign status_o.flags           = flags_q;
  assign status_o.feat_write_seen = feat_seen_q;

  // a sticky bit may only drop on the edge after clr_i was seen
  a_sticky_hold: assert property (
    @(posedge clk) disable iff (!rst_n)
    (|($past({feat_seen_q, flags_q}) & ~{feat_seen_q, flags_q})) |-> $past(clr_i)
  );

endmodule

/* hw/pe_snapshot.sv */
module pe_snapshot import gat_dbg_pkg::*; #(
  parameter int unsigned NUM_PE          = 16,
  parameter int unsigned PE_LANE         = 2,
  parameter int unsigned TRIG_ADDR_A     = 10,
  parameter int unsigned TRIG_ADDR_B     = 20,
  parameter int unsigned FEAT_ADDR_LIMIT = 43328
) (
  input  logic                    clk,
  input  logic                    rst_n,
  input  logic                    clr_i,
  input  logic                    spmm_rdy_i,
  input  logic                    sm_vld_i,
  input  logic                    feat_ena_i,
  input  wgt_addr_t               wgt_addr_i,
  input  pe_data_t [NUM_PE-1:0]   sppe_i,
  input  feat_addr_t              feat_addr_i,
  snapshot_if.src                 snap_o
);

  logic       trig_a;
  logic       trig_b;
  logic       feat_over;
  pe_data_t   lane_val;
  pe_data_t   snap_a_q;
  pe_data_t   snap_b_q;
  logic       hit_a_q;
  logic       hit_b_q;
  dbg_word_t  sm_cnt_q;
  logic       over_seen_q;
  feat_addr_t last_over_q;

  assign lane_val  = sppe_i[PE_LANE];
  assign trig_a    = spmm_rdy_i && (wgt_addr_i == wgt_addr_t'(TRIG_ADDR_A));
  assign trig_b    = spmm_rdy_i && (wgt_addr_i == wgt_addr_t'(TRIG_ADDR_B));
  assign feat_over = feat_ena_i && (32'(feat_addr_i) >= FEAT_ADDR_LIMIT);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      snap_a_q    <= '0;
      snap_b_q    <= '0;
      hit_a_q     <= 1'b0;
      hit_b_q     <= 1'b0;
      sm_cnt_q    <= '0;
      over_seen_q <= 1'b0;
      last_over_q <= '0;
    end else if (clr_i) begin
      snap_a_q    <= '0;
      snap_b_q    <= '0;
      hit_a_q     <= 1'b0;
      hit_b_q     <= 1'b0;
      sm_cnt_q    <= '0;
      over_seen_q <= 1'b0;
      last_over_q <= '0;
    end else begin
      // a later trigger simply overwrites the earlier capture
      if (trig_a) begin
        snap_a_q <= lane_val;
        hit_a_q  <= 1'b1;
      end
      if (trig_b) begin
        snap_b_q <= lane_val;
        hit_b_q  <= 1'b1;
      end
      if (sm_vld_i) begin
        sm_cnt_q <= sm_cnt_q + 1'b1;
      end
      if (feat_over) begin
        over_seen_q <= 1'b1;
        last_over_q <= feat_addr_i;
      end
    end
  end

  assign snap_o.snap_a         = snap_a_q;
  assign snap_o.snap_b         = snap_b_q;
  assign snap_o.snap_a_hit     = hit_a_q;
  assign snap_o.snap_b_hit     = hit_b_q;
  assign snap_o.sm_vld_count   = sm_cnt_q;
  assign snap_o.feat_over_seen = over_seen_q;
  assign snap_o.feat_last_over = last_over_q;

  // two equal triggers would make the second snapshot meaningless
  a_param_ok: assert property (
    @(posedge clk) (TRIG_ADDR_A != TRIG_ADDR_B) && (PE_LANE < NUM_PE)
  );

  a_cnt_step: assert property (
    @(posedge clk) disable iff (!rst_n)
    (sm_cnt_q == $past(sm_cnt_q)) ||
    (sm_cnt_q == dbg_word_t'($past(sm_cnt_q) + 1'b1)) ||
    ((sm_cnt_q == '0) && $past(clr_i))
  );

endmodule

/* hw/debug_word_mux.sv */
module debug_word_mux import gat_dbg_pkg::*; #(
  parameter int unsigned NUM_SPARSE_DATA = 12,
  parameter int unsigned BUILD_TAG       = 12100
) (
  input  logic [1:0]      sel_i,
  stage_flags_if.dst      status_i,
  snapshot_if.dst         snap_i,
  output dbg_word_t       debug_1_o,
  output dbg_word_t       debug_2_o,
  output dbg_word_t       debug_3_o
);

  dbg_word_t status_word;

  // static identification word
  assign debug_1_o = {16'(BUILD_TAG), 16'(NUM_SPARSE_DATA)};

  always_comb begin
    status_word        = '0;
    status_word[7:0]   = status_i.flags;
    status_word[8]     = status_i.feat_write_seen;
    status_word[9]     = snap_i.feat_over_seen;
    status_word[10]    = snap_i.snap_a_hit;
    status_word[11]    = snap_i.snap_b_hit;
  end

  // all sources are registered upstream, so this stays purely combinational
  always_comb begin
    case (sel_i)
      2'd0: begin
        debug_2_o = status_word;
      end
      2'd1: begin
        debug_2_o = dbg_word_t'(snap_i.snap_a);
      end
      2'd2: begin
        debug_2_o = dbg_word_t'(snap_i.snap_b);
      end
      default: begin
        debug_2_o = dbg_word_t'(snap_i.feat_last_over);
      end
    endcase
  end

  assign debug_3_o = snap_i.sm_vld_count;

endmodule

/* hw/gat_debug_top.sv */
module gat_debug_top import gat_dbg_pkg::*; #(
  parameter int unsigned NUM_PE          = 16,
  parameter int unsigned PE_LANE         = 2,
  parameter int unsigned TRIG_ADDR_A     = 10,
  parameter int unsigned TRIG_ADDR_B     = 20,
  parameter int unsigned FEAT_ADDR_LIMIT = 43328,
  parameter int unsigned NUM_SPARSE_DATA = 12,
  parameter int unsigned BUILD_TAG       = 12100
) (
  input  logic                    clk,
  input  logic                    rst_n,
  input  logic                    clr_i,
  input  logic [1:0]              sel_i,
  input  logic                    spmm_vld_i,
  input  logic                    spmm_rdy_i,
  input  logic                    dmvm_vld_i,
  input  logic                    dmvm_rdy_i,
  input  logic                    sm_vld_i,
  input  logic                    sm_rdy_i,
  input  logic                    aggr_vld_i,
  input  logic                    aggr_rdy_i,
  input  wgt_addr_t               wgt_addr_i,
  input  pe_data_t [NUM_PE-1:0]   sppe_i,
  input  logic                    feat_ena_i,
  input  feat_addr_t              feat_addr_i,
  output dbg_word_t               debug_1_o,
  output dbg_word_t               debug_2_o,
  output dbg_word_t               debug_3_o
);

  stage_flags_if status_bus ();
  snapshot_if    snap_bus ();

  stage_flag_latch u_stage_flag_latch (
    .clk        (clk),
    .rst_n      (rst_n),
    .clr_i      (clr_i),
    .spmm_vld_i (spmm_vld_i),
    .spmm_rdy_i (spmm_rdy_i),
    .dmvm_vld_i (dmvm_vld_i),
    .dmvm_rdy_i (dmvm_rdy_i),
    .sm_vld_i   (sm_vld_i),
    .sm_rdy_i   (sm_rdy_i),
    .aggr_vld_i (aggr_vld_i),
    .aggr_rdy_i (aggr_rdy_i),
    .feat_ena_i (feat_ena_i),
    .status_o   (status_bus.src)
  );

  pe_snapshot #(
    .NUM_PE          (NUM_PE),
    .PE_LANE         (PE_LANE),
    .TRIG_ADDR_A     (TRIG_ADDR_A),
    .TRIG_ADDR_B     (TRIG_ADDR_B),
    .FEAT_ADDR_LIMIT (FEAT_ADDR_LIMIT)
  ) u_pe_snapshot (
    .clk         (clk),
    .rst_n       (rst_n),
    .clr_i       (clr_i),
    .spmm_rdy_i  (spmm_rdy_i),
    .sm_vld_i    (sm_vld_i),
    .feat_ena_i  (feat_ena_i),
    .wgt_addr_i  (wgt_addr_i),
    .sppe_i      (sppe_i),
    .feat_addr_i (feat_addr_i),
    .snap_o      (snap_bus.src)
  );

  debug_word_mux #(
    .NUM_SPARSE_DATA (NUM_SPARSE_DATA),
    .BUILD_TAG       (BUILD_TAG)
  ) u_debug_word_mux (
    .sel_i     (sel_i),
    .status_i  (status_bus.dst),
    .snap_i    (snap_bus.dst),
    .debug_1_o (debug_1_o),
    .debug_2_o (debug_2_o),
    .debug_3_o (debug_3_o)
  );

endmodule

/* tests/tb_gat_debug_vectors.svh */
// columns: strobes {spmm_vld spmm_rdy dmvm_vld dmvm_rdy sm_vld sm_rdy aggr_vld aggr_rdy},
// weight addr, lane value, random lanes, feat_ena, feat addr, clr, sel, exp debug_2, exp debug_3
`ifndef TB_GAT_DEBUG_VECTORS_SVH
`define TB_GAT_DEBUG_VECTORS_SVH

task automatic load_vector_table();
  // each stage strobe adds its own flag, clear wins over a full strobe word
  add_row(8'h00, 0, 0, 1, 0, 0, 0, 0, 32'h0000_0000, 0);
  add_row(8'h80, 0, 0, 1, 0, 0, 0, 0, 32'h0000_0080, 0);
  add_row(8'h40, 0, 0, 1, 0, 0, 0, 0, 32'h0000_00c0, 0);
  add_row(8'h20, 0, 0, 1, 0, 0, 0, 0, 32'h0000_00e0, 0);
  add_row(8'h10, 0, 0, 1, 0, 0, 0, 0, 32'h0000_00f0, 0);
  add_row(8'h08, 0, 0, 1, 0, 0, 0, 0, 32'h0000_00f8, 1);
  add_row(8'h04, 0, 0, 1, 0, 0, 0, 0, 32'h0000_00fc, 1);
  add_row(8'h02, 0, 0, 1, 0, 0, 0, 0, 32'h0000_00fe, 1);
  add_row(8'h01, 0, 0, 1, 0, 0, 0, 0, 32'h0000_00ff, 1);
  add_row(8'h00, 0, 0, 1, 0, 0, 0, 0, 32'h0000_00ff, 1);
  add_row(8'h00, 0, 0, 1, 0, 0, 1, 0, 32'h0000_0000, 0);
  add_row(8'hff, 0, 0, 1, 0, 0, 1, 0, 32'h0000_0000, 0);
  // snapshots on both trigger addresses, then rows that must not capture
  add_row(8'h40, 10, 12'h5a3, 0, 0, 0, 0, 1, 32'h0000_05a3, 0);
  add_row(8'h40, 20, 12'hc3e, 0, 0, 0, 0, 2, 32'h0000_0c3e, 0);
  add_row(8'h00, 10, 0, 1, 0, 0, 0, 1, 32'h0000_05a3, 0);
  add_row(8'h40, 11, 0, 1, 0, 0, 0, 2, 32'h0000_0c3e, 0);
  add_row(8'h00, 0, 0, 1, 0, 0, 0, 0, 32'h0000_0c40, 0);
  add_row(8'h40, 10, 12'h7ff, 0, 0, 0, 0, 1, 32'h0000_07ff, 0);
  add_row(8'h00, 0, 0, 1, 0, 0, 1, 0, 32'h0000_0000, 0);
  // softmax valid count
  add_row(8'h08, 0, 0, 1, 0, 0, 0, 0, 32'h0000_0008, 1);
  add_row(8'h08, 0, 0, 1, 0, 0, 0, 0, 32'h0000_0008, 2);
  add_row(8'h08, 0, 0, 1, 0, 0, 0, 0, 32'h0000_0008, 3);
  add_row(8'h08, 0, 0, 1, 0, 0, 0, 0, 32'h0000_0008, 4);
  add_row(8'h08, 0, 0, 1, 0, 0, 0, 0, 32'h0000_0008, 5);
  add_row(8'h00, 0, 0, 1, 0, 0, 0, 0, 32'h0000_0008, 5);
  add_row(8'h00, 0, 0, 1, 0, 0, 1, 0, 32'h0000_0000, 0);
  // feature writes around the 43328 limit
  add_row(8'h00, 0, 0, 1, 1, 1000, 0, 0, 32'h0000_0100, 0);
  add_row(8'h00, 0, 0, 1, 1, 43327, 0, 0, 32'h0000_0100, 0);
  add_row(8'h00, 0, 0, 1, 1, 43328, 0, 0, 32'h0000_0300, 0);
  add_row(8'h00, 0, 0, 1, 0, 0, 0, 3, 32'h0000_a940, 0);
  add_row(8'h00, 0, 0, 1, 1, 16'hfff0, 0, 3, 32'h0000_fff0, 0);
  add_row(8'h00, 0, 0, 1, 1, 100, 0, 3, 32'h0000_fff0, 0);
  add_row(8'h00, 0, 0, 1, 0, 50000, 0, 3, 32'h0000_fff0, 0);
  add_row(8'h00, 0, 0, 1, 0, 0, 0, 0, 32'h0000_0300, 0);
  add_row(8'h00, 0, 0, 1, 0, 0, 1, 0, 32'h0000_0000, 0);
endtask

`endif

/* tests/tb_gat_debug.sv */
module tb_gat_debug import gat_dbg_pkg::*; ();

  localparam int NUM_PE        = 16;
  localparam int PE_LANE       = 2;
  localparam int MAX_ROWS      = 64;
  localparam int RESET_TIMEOUT = 50;
  localparam int DRAIN_TIMEOUT = 20;
  // build tag in the upper half, sparse data count in the lower half
  localparam dbg_word_t EXP_ID = {16'd12100, 16'd12};

  logic                  clk = 1'b0;
  logic                  rst_n;
  logic                  clr;
  logic [1:0]            sel;
  logic                  spmm_vld, spmm_rdy, dmvm_vld, dmvm_rdy;
  logic                  sm_vld, sm_rdy, aggr_vld, aggr_rdy;
  wgt_addr_t             wgt_addr;
  pe_data_t [NUM_PE-1:0] sppe;
  logic                  feat_ena;
  feat_addr_t            feat_addr;
  dbg_word_t             debug_1, debug_2, debug_3;

  logic [7:0] tbl_strb  [MAX_ROWS];
  wgt_addr_t  tbl_waddr [MAX_ROWS];
  pe_data_t   tbl_lane  [MAX_ROWS];
  logic       tbl_rnd   [MAX_ROWS];
  logic       tbl_fen   [MAX_ROWS];
  feat_addr_t tbl_faddr [MAX_ROWS];
  logic       tbl_clr   [MAX_ROWS];
  logic [1:0] tbl_sel   [MAX_ROWS];
  dbg_word_t  tbl_exp2  [MAX_ROWS];
  dbg_word_t  tbl_exp3  [MAX_ROWS];
  int         num_rows = 0;
  int         n_checks = 0;
  int         n_errors = 0;
  integer     seed = 32'haa72;

  gat_debug_top #(
    .NUM_PE  (NUM_PE),
    .PE_LANE (PE_LANE)
  ) UUT (
    .clk         (clk),
    .rst_n       (rst_n),
    .clr_i       (clr),
    .sel_i       (sel),
    .spmm_vld_i  (spmm_vld),
    .spmm_rdy_i  (spmm_rdy),
    .dmvm_vld_i  (dmvm_vld),
    .dmvm_rdy_i  (dmvm_rdy),
    .sm_vld_i    (sm_vld),
    .sm_rdy_i    (sm_rdy),
    .aggr_vld_i  (aggr_vld),
    .aggr_rdy_i  (aggr_rdy),
    .wgt_addr_i  (wgt_addr),
    .sppe_i      (sppe),
    .feat_ena_i  (feat_ena),
    .feat_addr_i (feat_addr),
    .debug_1_o   (debug_1),
    .debug_2_o   (debug_2),
    .debug_3_o   (debug_3)
  );

  always #10 clk = ~clk;

  initial begin
    rst_n = 1'b0;
    repeat (8) @(posedge clk);
    rst_n <= 1'b1;
  end

  task automatic add_row(input logic [7:0] strb, input int waddr, input int lane,
                         input bit rnd, input bit fen, input int faddr, input bit clr_v,
                         input int sel_v, input dbg_word_t exp2, input dbg_word_t exp3);
    if (num_rows >= MAX_ROWS) begin
      $display("vector table is full, row %0d was dropped", num_rows);
      n_errors++;
    end else begin
      tbl_strb[num_rows]  = strb;
      tbl_waddr[num_rows] = wgt_addr_t'(waddr);
      tbl_lane[num_rows]  = pe_data_t'(lane);
      tbl_rnd[num_rows]   = rnd;
      tbl_fen[num_rows]   = fen;
      tbl_faddr[num_rows] = feat_addr_t'(faddr);
      tbl_clr[num_rows]   = clr_v;
      tbl_sel[num_rows]   = sel_v[1:0];
      tbl_exp2[num_rows]  = exp2;
      tbl_exp3[num_rows]  = exp3;
      num_rows++;
    end
  endtask

  `include "tb_gat_debug_vectors.svh"

  task automatic check_value(input dbg_word_t got, input dbg_word_t exp, input string what);
    n_checks++;
    if (got !== exp) begin
      n_errors++;
      $display("Error at time %0t: %s is %h, expected %h", $time, what, got, exp);
    end
  endtask

  // other lanes always carry noise so a wrong lane select shows up
  task automatic drive_lanes(input logic rnd, input pe_data_t lane);
    pe_data_t [NUM_PE-1:0] v;
    for (int k = 0; k < NUM_PE; k++) begin
      v[k] = pe_data_t'($random(seed));
    end
    if (!rnd) begin
      v[PE_LANE] = lane;
    end
    sppe <= v;
  endtask

  task automatic drive_idle();
    {spmm_vld, spmm_rdy, dmvm_vld, dmvm_rdy} <= '0;
    {sm_vld, sm_rdy, aggr_vld, aggr_rdy} <= '0;
    feat_ena <= 1'b0;
    clr      <= 1'b0;
  endtask

  task automatic apply_row(input int r);
    @(posedge clk);
    {spmm_vld, spmm_rdy, dmvm_vld, dmvm_rdy} <= tbl_strb[r][7:4];
    {sm_vld, sm_rdy, aggr_vld, aggr_rdy} <= tbl_strb[r][3:0];
    wgt_addr  <= tbl_waddr[r];
    feat_ena  <= tbl_fen[r];
    feat_addr <= tbl_faddr[r];
    clr       <= tbl_clr[r];
    sel       <= tbl_sel[r];
    drive_lanes(tbl_rnd[r], tbl_lane[r]);
    // the row is captured on this edge, sel stays so the check sees its word
    @(posedge clk);
    drive_idle();
    @(negedge clk);
    check_value(debug_1, EXP_ID, $sformatf("row %0d debug_1", r));
    check_value(debug_2, tbl_exp2[r], $sformatf("row %0d debug_2", r));
    check_value(debug_3, tbl_exp3[r], $sformatf("row %0d debug_3", r));
  endtask

  task automatic wait_for_reset(output bit ok);
    int waited;
    waited = 0;
    while (rst_n !== 1'b1 && waited < RESET_TIMEOUT) begin
      @(posedge clk);
      waited++;
    end
    ok = (rst_n === 1'b1);
    if (!ok) begin
      $display("timeout: reset was not released within %0d cycles", RESET_TIMEOUT);
      n_errors++;
    end
  endtask

  task automatic drain_idle();
    int waited;
    waited = 0;
    @(posedge clk);
    drive_idle();
    sel <= 2'd0;
    @(negedge clk);
    while ((debug_2 !== '0 || debug_3 !== '0) && waited < DRAIN_TIMEOUT) begin
      @(negedge clk);
      waited++;
    end
    if (debug_2 !== '0 || debug_3 !== '0) begin
      $display("timeout: debug outputs did not return to zero after the last clear");
      n_errors++;
    end
  endtask

  task automatic report_and_finish();
    $display("checks: %0d, errors: %0d", n_checks, n_errors);
    if (n_errors == 0) begin
      $display("PASS: all tests");
    end else begin
      $display("FAIL: see errors above");
    end
    $finish;
  endtask

  initial begin
    bit ok;
    clr       = 1'b0;
    sel       = 2'd0;
    {spmm_vld, spmm_rdy, dmvm_vld, dmvm_rdy} = '0;
    {sm_vld, sm_rdy, aggr_vld, aggr_rdy} = '0;
    wgt_addr  = '0;
    sppe      = '0;
    feat_ena  = 1'b0;
    feat_addr = '0;
    load_vector_table();
    wait_for_reset(ok);
    if (ok) begin
      @(negedge clk);
      check_value(debug_1, EXP_ID, "reset debug_1");
      check_value(debug_2, '0, "reset debug_2");
      check_value(debug_3, '0, "reset debug_3");
      for (int r = 0; r < num_rows; r++) begin
        apply_row(r);
      end
      drain_idle();
    end
    report_and_finish();
  end

endmodule

/* flist.f */
+incdir+tests
hw/gat_dbg_pkg.sv
hw/dbg_if.sv
hw/stage_flag_latch.sv
hw/pe_snapshot.sv
hw/debug_word_mux.sv
hw/gat_debug_top.sv
tests/tb_gat_debug.sv
